// ==== rtl/efb_bridge_params.svh ====
`ifndef EFB_BRIDGE_PARAMS_SVH
`define EFB_BRIDGE_PARAMS_SVH

// ==============================
// Bus widths
// ==============================
`define EFB_REG_W   32 // Register bus data width.
`define EFB_ADDR_W  8  // Wishbone address width.
`define EFB_BYTE_W  8  // Wishbone data width.
`define EFB_LEN_W   2  // Burst length field, bytes minus one.
`define EFB_OFS_W   2  // Register offset width.

// ==============================
// Register map
// ==============================
`define EFB_OFS_CTRL  0 // Control on write, status on read.
`define EFB_OFS_WDATA 1
`define EFB_OFS_RDATA 2

// Gap before the second byte of a flash command.
`define EFB_SETTLE_CYCLES 35

`endif

// ==== rtl/efb_bridge_pkg.sv ====
`default_nettype none

`include "efb_bridge_params.svh"

package efb_bridge_pkg;

    typedef logic [`EFB_REG_W-1:0]  reg_word_t;
    typedef logic [`EFB_ADDR_W-1:0] wb_addr_t;
    typedef logic [`EFB_BYTE_W-1:0] wb_byte_t;
    typedef logic [`EFB_LEN_W-1:0]  burst_len_t;
    typedef logic [`EFB_OFS_W-1:0]  reg_ofs_t;

    // Register file towards the sequencer.
    typedef struct packed {
        logic      control_valid; // One cycle per control write.
        reg_word_t control_wdata;
        reg_word_t data_wdata;
    } scb_req_t;

    typedef struct packed {
        reg_word_t control_rdata; // Status word.
        reg_word_t data_rdata;
    } scb_rsp_t;

    // Wishbone classic, master to slave.
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_byte_t dat;
    } wb_req_t;

    typedef struct packed {
        wb_byte_t dat;
        logic     ack;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/ctrl_regs.sv ====
`default_nettype none

`include "efb_bridge_params.svh"

module ctrl_regs
    import efb_bridge_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      reg_valid_i,
    input  logic      reg_write_i,
    input  reg_ofs_t  reg_ofs_i,
    input  reg_word_t reg_wdata_i,
    output reg_word_t reg_rdata_o,

    output scb_req_t  scb_req_o,
    input  scb_rsp_t  scb_rsp_i
);

    logic      reg_wr;
    logic      ctrl_sel;
    logic      wdata_sel;
    logic      rdata_sel;
    reg_word_t wdata_q;

    // ==============================
    // Offset decode
    // ==============================
    always_comb begin
        reg_wr    = reg_valid_i && reg_write_i;
        ctrl_sel  = (reg_ofs_i == reg_ofs_t'(`EFB_OFS_CTRL));
        wdata_sel = (reg_ofs_i == reg_ofs_t'(`EFB_OFS_WDATA));
        rdata_sel = (reg_ofs_i == reg_ofs_t'(`EFB_OFS_RDATA));
    end

    // Bytes to be written by the next burst, most significant first.
    always_ff @(posedge clk) begin
        if (reset) begin
            wdata_q <= '0;
        end else if (reg_wr && wdata_sel) begin
            wdata_q <= reg_wdata_i;
        end
    end

    // ==============================
    // Sequencer request
    // ==============================
    // The control word goes straight through, the strobe marks the cycle
    // in which it is valid.
    always_comb begin
        scb_req_o.control_valid = reg_wr && ctrl_sel;
        scb_req_o.control_wdata = reg_wdata_i;
        scb_req_o.data_wdata    = wdata_q;
    end

    // ==============================
    // Read mux
    // ==============================
    always_comb begin
        reg_rdata_o = '0; // Unmapped offsets read as zero.
        if (ctrl_sel) begin
            reg_rdata_o = scb_rsp_i.control_rdata;
        end else if (wdata_sel) begin
            reg_rdata_o = wdata_q;
        end else if (rdata_sel) begin
            reg_rdata_o = scb_rsp_i.data_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/efb_sequencer.sv ====
`default_nettype none

`include "efb_bridge_params.svh"

module efb_sequencer
    import efb_bridge_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  scb_req_t scb_req_i,
    output scb_rsp_t scb_rsp_o,

    output wb_req_t  wb_req_o,
    input  wb_rsp_t  wb_rsp_i
);

    localparam int SETTLE_W = $clog2(`EFB_SETTLE_CYCLES + 1);

    logic                start;
    logic                ctrl_start;
    logic                ctrl_write;
    logic                ctrl_settle;
    burst_len_t          ctrl_len;
    wb_addr_t            ctrl_addr;

    logic                busy;
    logic                request;
    logic                ack;
    logic                last_ack;
    logic                write;
    wb_addr_t            address;
    burst_len_t          remaining;
    logic [SETTLE_W-1:0] settle_cnt;
    reg_word_t           wdata_shift;
    reg_word_t           rdata_shift;

    // ==============================
    // Control word fields
    // ==============================
    always_comb begin
        ctrl_start  = scb_req_i.control_wdata[0];
        ctrl_write  = scb_req_i.control_wdata[1];
        ctrl_len    = scb_req_i.control_wdata[3:2];
        ctrl_settle = scb_req_i.control_wdata[4];
        ctrl_addr   = scb_req_i.control_wdata[15:8];
    end

    assign start    = scb_req_i.control_valid && ctrl_start && !busy; // Ignored while busy.
    assign ack      = wb_rsp_i.ack;
    assign last_ack = ack && (remaining == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (last_ack) begin
            busy <= 1'b0;
        end
    end

    // The first request goes out with start, later ones wait for the
    // settle counter.
    always_ff @(posedge clk) begin
        if (reset) begin
            request <= 1'b0;
        end else if (start) begin
            request <= 1'b1;
        end else if (ack) begin
            request <= 1'b0;
        end else if (busy && !request && settle_cnt == '0) begin
            request <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            settle_cnt <= '0;
        end else if (start && ctrl_settle) begin
            settle_cnt <= SETTLE_W'(`EFB_SETTLE_CYCLES);
        end else if (settle_cnt != '0) begin
            settle_cnt <= settle_cnt - 1'b1;
        end
    end

    // ==============================
    // Burst state and data shifting
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            write       <= 1'b0;
            address     <= '0;
            remaining   <= '0;
            wdata_shift <= '0;
            rdata_shift <= '0;
        end else begin
            if (start) begin
                write       <= ctrl_write;
                address     <= ctrl_addr;
                remaining   <= ctrl_len;
                wdata_shift <= scb_req_i.data_wdata;
            end else if (ack) begin
                if (remaining != '0) begin
                    remaining <= remaining - 1'b1;
                end
                wdata_shift <= {wdata_shift[`EFB_REG_W-`EFB_BYTE_W-1:0], wb_byte_t'(0)};
            end
            // Read bytes enter at the low end; older ones move up.
            if (ack && !write) begin
                rdata_shift <= {rdata_shift[`EFB_REG_W-`EFB_BYTE_W-1:0], wb_rsp_i.dat};
            end
        end
    end

    // ==============================
    // Outputs
    // ==============================
    always_comb begin
        wb_req_o.cyc = request;
        wb_req_o.stb = request;
        wb_req_o.we  = write;
        wb_req_o.adr = address;
        wb_req_o.dat = wdata_shift[`EFB_REG_W-1 -: `EFB_BYTE_W];

        scb_rsp_o.control_rdata = reg_word_t'({address, 4'b0000, remaining, write, busy});
        scb_rsp_o.data_rdata    = rdata_shift;
    end

endmodule

`default_nettype wire

// ==== rtl/efb_wb_slave.sv ====
`default_nettype none

`include "efb_bridge_params.svh"

module efb_wb_slave
    import efb_bridge_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    localparam int DEPTH = 2 ** `EFB_ADDR_W;

    wb_byte_t mem [DEPTH];
    logic     sel;
    logic     ack_q;
    wb_byte_t rdata_q;

    assign sel = wb_req_i.cyc && wb_req_i.stb;

    // ==============================
    // Acknowledge
    // ==============================
    // One pulse per strobe. The low ack in between lets the next
    // transfer start a fresh handshake.
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= sel && !ack_q;
        end
    end

    // ==============================
    // Byte array
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (sel && wb_req_i.we && ack_q) begin
            mem[wb_req_i.adr] <= wb_req_i.dat; // Stored on the ack edge.
        end
    end

    // Read data is captured together with the rising ack.
    always_ff @(posedge clk) begin
        if (sel && !ack_q) begin
            rdata_q <= mem[wb_req_i.adr];
        end
    end

    always_comb begin
        wb_rsp_o.ack = ack_q;
        wb_rsp_o.dat = rdata_q;
    end

endmodule

`default_nettype wire

// ==== rtl/efb_bridge_top.sv ====
`default_nettype none

module efb_bridge_top
    import efb_bridge_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      reg_valid_i,
    input  logic      reg_write_i,
    input  reg_ofs_t  reg_ofs_i,
    input  reg_word_t reg_wdata_i,
    output reg_word_t reg_rdata_o
);

    scb_req_t scb_req;
    scb_rsp_t scb_rsp;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;

    // ==============================
    // Register file
    // ==============================
    ctrl_regs i_ctrl_regs (
        .clk        (clk),
        .reset      (reset),
        .reg_valid_i(reg_valid_i),
        .reg_write_i(reg_write_i),
        .reg_ofs_i  (reg_ofs_i),
        .reg_wdata_i(reg_wdata_i),
        .reg_rdata_o(reg_rdata_o),
        .scb_req_o  (scb_req),
        .scb_rsp_i  (scb_rsp)
    );

    // Burst engine, the only Wishbone master.
    efb_sequencer i_efb_sequencer (
        .clk      (clk),
        .reset    (reset),
        .scb_req_i(scb_req),
        .scb_rsp_o(scb_rsp),
        .wb_req_o (wb_req),
        .wb_rsp_i (wb_rsp)
    );

    efb_wb_slave i_efb_wb_slave (
        .clk     (clk),
        .reset   (reset),
        .wb_req_i(wb_req),
        .wb_rsp_o(wb_rsp)
    );

endmodule

`default_nettype wire

// ==== dv/efb_bridge_assert.sv ====
`default_nettype none

module efb_bridge_assert
    import efb_bridge_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     busy_i,
    input logic     request_i,
    input scb_req_t scb_req_i,
    input scb_rsp_t scb_rsp_i,
    input wb_req_t  wb_req_i,
    input wb_rsp_t  wb_rsp_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic start_seen;

    assign start_seen = scb_req_i.control_valid && scb_req_i.control_wdata[0];

    // ==============================
    // Wishbone handshake
    // ==============================
    ack_in_request: assert property (@(posedge clk) disable iff (reset)
        wb_rsp_i.ack |-> request_i) else $error("Wishbone ack outside a request.");

    request_drops_after_ack: assert property (@(posedge clk) disable iff (reset)
        wb_rsp_i.ack |=> !request_i) else $error("Request still high after its ack.");

    // Classic cycles keep cyc and stb up together until the slave answers.
    cyc_stb_held_until_ack: assert property (@(posedge clk) disable iff (reset)
        wb_req_i.cyc && !wb_rsp_i.ack |=> wb_req_i.cyc && wb_req_i.stb)
        else $error("Wishbone cyc and stb not held together until ack.");

    // A start while busy must leave the running burst alone.
    busy_start_ignored: assert property (@(posedge clk) disable iff (reset)
        start_seen && busy_i |=> $stable(scb_rsp_i.control_rdata[15:8])
                                 && $stable(scb_rsp_i.control_rdata[1]))
        else $error("Start accepted while busy.");

endmodule

bind efb_sequencer efb_bridge_assert i_efb_bridge_assert (
    .clk      (clk),
    .reset    (reset),
    .busy_i   (busy),
    .request_i(request),
    .scb_req_i(scb_req_i),
    .scb_rsp_i(scb_rsp_o),
    .wb_req_i (wb_req_o),
    .wb_rsp_i (wb_rsp_i)
);

`default_nettype wire

// ==== dv/efb_bridge_tb.sv ====
`default_nettype none

`include "efb_bridge_params.svh"

module efb_bridge_tb
    import efb_bridge_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_CYCLES = 12 * 4 * 40 + 500; // Twelve bursts of four settled bytes.

    logic      clk = 1'b0;
    logic      reset;
    logic      reg_valid;
    logic      reg_write;
    reg_ofs_t  reg_ofs;
    reg_word_t reg_wdata;
    reg_word_t reg_rdata;

    integer    seed = 32'hbf7f4fd0;
    int        cycle_count = 0;
    int        error_count = 0;
    int        test_count = 0;
    int        checks_queued = 0;
    int        checks_done = 0;
    wb_byte_t  shadow_mem [256]; // Reference copy of the EFB byte array.
    reg_word_t rdata_model = '0; // Expected contents of the read-data register.
    string     name_q [$];
    reg_word_t expected_q [$];
    reg_word_t actual_q [$];

    efb_bridge_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .reg_valid_i(reg_valid),
        .reg_write_i(reg_write),
        .reg_ofs_i  (reg_ofs),
        .reg_wdata_i(reg_wdata),
        .reg_rdata_o(reg_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the bursts did not finish within %0d cycles.", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ==============================
    // Reference model
    // ==============================
    function automatic reg_word_t control_word(wb_addr_t addr, int len, bit write, bit settle);
        return {16'h0000, addr, 3'b000, settle, burst_len_t'(len - 1), write, 1'b1};
    endfunction

    // Only the last byte of a write burst stays in memory.
    function automatic wb_byte_t last_write_byte(reg_word_t data, int len);
        return data[31 - 8 * (len - 1) -: 8];
    endfunction

    function automatic reg_word_t expected_read(reg_word_t prev, wb_addr_t addr, int len);
        reg_word_t word;
        word = prev;
        for (int i = 0; i < len; i++) begin
            word = {word[23:0], shadow_mem[addr]}; // Each byte enters at the low end.
        end
        return word;
    endfunction

    // ==============================
    // Register bus tasks
    // ==============================
    task automatic queue_check(input string name, input reg_word_t expected,
                               input reg_word_t actual);
        name_q.push_back(name);
        expected_q.push_back(expected);
        actual_q.push_back(actual);
        checks_queued++;
    endtask

    // Both tasks start and end on a falling edge.
    task automatic write_reg(input int ofs, input reg_word_t data);
        reg_valid = 1'b1;
        reg_write = 1'b1;
        reg_ofs   = reg_ofs_t'(ofs);
        reg_wdata = data;
        @(negedge clk);
        reg_valid = 1'b0;
        reg_write = 1'b0;
    endtask

    task automatic read_reg(input int ofs, output reg_word_t data);
        reg_ofs = reg_ofs_t'(ofs);
        #(CLK_PERIOD / 4);
        data = reg_rdata;
        @(negedge clk);
    endtask

    task automatic wait_idle(input string name, input wb_addr_t addr, input bit write,
                             output int cycles);
        reg_word_t status;
        read_reg(`EFB_OFS_CTRL, status);
        queue_check({name, " busy"}, {16'h0000, addr, 6'b000000, write, 1'b1},
                    status & 32'h0000_ff03);
        cycles = 0;
        while (status[0]) begin
            cycles++;
            read_reg(`EFB_OFS_CTRL, status);
        end
        queue_check({name, " idle"}, 32'h0, status & 32'h0000_000d);
    endtask

    task automatic write_burst(input string name, input wb_addr_t addr, input reg_word_t data,
                               input int len, input bit settle, output int cycles);
        write_reg(`EFB_OFS_WDATA, data);
        write_reg(`EFB_OFS_CTRL, control_word(addr, len, 1'b1, settle));
        wait_idle(name, addr, 1'b1, cycles);
        shadow_mem[addr] = last_write_byte(data, len);
    endtask

    task automatic read_burst(input string name, input wb_addr_t addr, input int len,
                              input bit settle, output int cycles);
        reg_word_t actual;
        write_reg(`EFB_OFS_CTRL, control_word(addr, len, 1'b0, settle));
        wait_idle(name, addr, 1'b0, cycles);
        read_reg(`EFB_OFS_RDATA, actual);
        rdata_model = expected_read(rdata_model, addr, len);
        queue_check({name, " data"}, rdata_model, actual);
    endtask

    task automatic check_latency(input string name, input int cycles, input int min_cycles,
                                 input int max_cycles);
        test_count++;
        if (cycles < min_cycles || cycles > max_cycles) begin
            error_count++;
            $display("Error: %s expected %0d to %0d cycles actual %0d", name, min_cycles,
                     max_cycles, cycles);
        end else begin
            $display("Pass: %s %0d cycles", name, cycles);
        end
    endtask

    // ==============================
    // Checker
    // ==============================
    initial begin : compare_results
        string     name;
        reg_word_t expected;
        reg_word_t actual;
        forever begin
            @(posedge clk);
            while (name_q.size() > 0) begin
                name     = name_q.pop_front();
                expected = expected_q.pop_front();
                actual   = actual_q.pop_front();
                test_count++;
                if (actual !== expected) begin
                    error_count++;
                    $display("Error: %s expected %08h actual %08h", name, expected, actual);
                end else begin
                    $display("Pass: %s %08h", name, actual);
                end
                checks_done++;
            end
        end
    end

    initial begin : run_tests
        reg_word_t value;
        reg_word_t data;
        wb_addr_t  addr;
        int        len;
        int        cycles;
        for (int i = 0; i < 256; i++) begin
            shadow_mem[i] = '0;
        end
        reset     = 1'b1;
        reg_valid = 1'b0;
        reg_write = 1'b0;
        reg_ofs   = '0;
        reg_wdata = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        read_reg(`EFB_OFS_CTRL, value);
        queue_check("idle status", 32'h0, value);
        read_reg(`EFB_OFS_RDATA, value);
        queue_check("idle read data", 32'h0, value);

        for (int t = 0; t < 4; t++) begin
            addr = wb_addr_t'($random(seed));
            data = $random(seed);
            len  = ($random(seed) & 3) + 1;
            write_burst($sformatf("write burst %0d", t), addr, data, len, 1'b0, cycles);
            read_burst($sformatf("single read %0d", t), addr, 1, 1'b0, cycles);
            read_burst($sformatf("read burst %0d", t), addr, len, 1'b0, cycles);
        end

        // The second start lands while the settled write is still running.
        addr = wb_addr_t'($random(seed));
        data = $random(seed);
        write_reg(`EFB_OFS_WDATA, data);
        write_reg(`EFB_OFS_CTRL, control_word(addr, 4, 1'b1, 1'b1));
        write_reg(`EFB_OFS_CTRL, control_word(addr + 8'd1, 1, 1'b0, 1'b0));
        wait_idle("start while busy", addr, 1'b1, cycles);
        shadow_mem[addr] = last_write_byte(data, 4);
        read_burst("start while busy target", addr, 1, 1'b0, cycles);
        read_burst("start while busy neighbour", addr + 8'd1, 1, 1'b0, cycles);

        addr = wb_addr_t'($random(seed));
        data = $random(seed);
        write_burst("settle write", addr, data, 4, 1'b1, cycles);
        check_latency("settle write latency", cycles, `EFB_SETTLE_CYCLES, MAX_CYCLES);
        read_burst("settle read", addr, 4, 1'b1, cycles);
        check_latency("settle read latency", cycles, `EFB_SETTLE_CYCLES, MAX_CYCLES);
        read_burst("plain read", addr, 4, 1'b0, cycles);
        check_latency("plain read latency", cycles, 1, 4 * 3); // Three cycles per byte.

        while (checks_done != checks_queued) @(posedge clk);
        $display("Tests: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== efb_bridge_top.f ====
+incdir+rtl
rtl/efb_bridge_pkg.sv
rtl/ctrl_regs.sv
rtl/efb_sequencer.sv
rtl/efb_wb_slave.sv
rtl/efb_bridge_top.sv
dv/efb_bridge_assert.sv
dv/efb_bridge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= efb_bridge_tb
FILE_LIST ?= efb_bridge_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_TEXT ?= TEST OK

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

# The run fails unless the pass line shows up in the simulation output.
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
